// ==== stage2_cnn_params.svh ====
`ifndef STAGE2_CNN_PARAMS_SVH
`define STAGE2_CNN_PARAMS_SVH

// ==========================================================================
// window geometry
// ==========================================================================

// kernel width and height
`define KX 5
`define KY 5
// input channels per output pixel
`define CI 3

// ==========================================================================
// bit widths
// ==========================================================================

// signed weight
`define W_BW 7
// signed feature-map element
`define IBW 20
// full product, fmap x weight
`define M_BW (`IBW + `W_BW)
// kernel total, 5 bits of growth for 25 terms
`define AK_BW (`M_BW + 5)
// channel sum, 2 bits of growth for up to 4 channels
`define ACI_BW (`AK_BW + 2)
// signed per-output-channel bias
`define B_BW 16
// output pixel, unsigned after relu
`define O_BW 24

`endif

// ==== stage2_cnn_pkg.sv ====
package stage2_cnn_pkg;

`include "stage2_cnn_params.svh"

	// ======================================================================
	// element types of the stage-2 datapath
	// ======================================================================

	// one kernel weight
	typedef logic signed [`W_BW-1:0] weight_t;
	// one feature-map element
	typedef logic signed [`IBW-1:0] fmap_t;
	// one fmap x weight product
	typedef logic signed [`M_BW-1:0] mul_t;
	// sum of 25 products of one channel
	typedef logic signed [`AK_BW-1:0] acc_kernel_t;
	// sum over all input channels
	typedef logic signed [`ACI_BW-1:0] acc_ch_t;
	// per-output-channel bias
	typedef logic signed [`B_BW-1:0] bias_t;
	// result pixel, never negative after relu
	typedef logic [`O_BW-1:0] ofmap_t;

endpackage

// ==== stage2_cnn_kernel.sv ====
`timescale 1ns/1ps
`include "stage2_cnn_params.svh"

module stage2_cnn_kernel (
	input  logic clk,
	input  logic reset_n,
	input  logic i_in_valid,
	// element y*KX + x of this channel's window
	input  stage2_cnn_pkg::fmap_t [`KX*`KY-1:0] i_in_fmap,
	input  stage2_cnn_pkg::weight_t [`KX*`KY-1:0] i_cnn_weight,
	output logic o_ot_valid,
	output stage2_cnn_pkg::acc_kernel_t o_ot_kernel_acc
);

	// products, row sums, total
	localparam int LATENCY = 3;

	// ======================================================================
	// valid delay line, doubles as stage enables
	// ======================================================================

	logic [LATENCY-1:0] r_valid;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= '0;
		end else begin
			r_valid <= {r_valid[LATENCY-2:0], i_in_valid};
		end
	end

	// ======================================================================
	// stage 1: 25 signed products
	// ======================================================================

	stage2_cnn_pkg::mul_t [`KX*`KY-1:0] r_mul;

	// one multiplier per window tap, captured on the input strobe
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_mul <= '0;
		end else if (i_in_valid) begin
			for (int k = 0; k < `KX*`KY; k++) begin
				r_mul[k] <= $signed(i_in_fmap[k]) * $signed(i_cnn_weight[k]);
			end
		end
	end

	// ======================================================================
	// stage 2: one partial sum per window row
	// ======================================================================

	stage2_cnn_pkg::acc_kernel_t [`KY-1:0] row_sum;
	stage2_cnn_pkg::acc_kernel_t [`KY-1:0] r_row_sum;

	// 5-input add per row, products sign-extended to the kernel width
	always_comb begin
		for (int y = 0; y < `KY; y++) begin
			row_sum[y] = '0;
			for (int x = 0; x < `KX; x++) begin
				row_sum[y] = row_sum[y] + r_mul[y*`KX + x];
			end
		end
	end

	// enabled one cycle behind the products
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_row_sum <= '0;
		end else if (r_valid[0]) begin
			r_row_sum <= row_sum;
		end
	end

	// ======================================================================
	// stage 3: kernel total
	// ======================================================================

	stage2_cnn_pkg::acc_kernel_t kernel_sum;
	stage2_cnn_pkg::acc_kernel_t r_acc_kernel;

	// second half of the 25-term tree
	always_comb begin
		kernel_sum = '0;
		for (int y = 0; y < `KY; y++) begin
			kernel_sum = kernel_sum + r_row_sum[y];
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_acc_kernel <= '0;
		end else if (r_valid[1]) begin
			r_acc_kernel <= kernel_sum;
		end
	end

	// total valid 3 cycles after the strobe
	assign o_ot_valid = r_valid[LATENCY-1];
	assign o_ot_kernel_acc = r_acc_kernel;

endmodule

// ==== stage2_channel_acc.sv ====
`timescale 1ns/1ps
`include "stage2_cnn_params.svh"

module stage2_channel_acc (
	input  logic clk,
	input  logic reset_n,
	// kernels run in lockstep, one valid for all
	input  logic i_in_valid,
	// one kernel total per input channel
	input  stage2_cnn_pkg::acc_kernel_t [`CI-1:0] i_kernel_acc,
	output logic o_ot_valid,
	output stage2_cnn_pkg::acc_ch_t o_ot_ch_acc
);

	// ======================================================================
	// cross-channel adder
	// ======================================================================

	stage2_cnn_pkg::acc_ch_t ch_sum;
	stage2_cnn_pkg::acc_ch_t r_ch_acc;
	logic r_valid;

	// each total sign-extended to the channel sum width
	always_comb begin
		ch_sum = '0;
		for (int c = 0; c < `CI; c++) begin
			ch_sum = ch_sum + $signed(i_kernel_acc[c]);
		end
	end

	// hold the last sum between strobes
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_ch_acc <= '0;
		end else if (i_in_valid) begin
			r_ch_acc <= ch_sum;
		end
	end

	// one register of valid delay
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_in_valid;
		end
	end

	assign o_ot_valid = r_valid;
	assign o_ot_ch_acc = r_ch_acc;

endmodule

// ==== stage2_bias_relu.sv ====
`timescale 1ns/1ps
`include "stage2_cnn_params.svh"

module stage2_bias_relu (
	input  logic clk,
	input  logic reset_n,
	input  logic i_in_valid,
	input  stage2_cnn_pkg::acc_ch_t i_ch_acc,
	// held stable while its pixel is in flight
	input  stage2_cnn_pkg::bias_t i_bias,
	output logic o_ot_valid,
	output stage2_cnn_pkg::ofmap_t o_ot_fmap
);

	// one extra bit so the bias add cannot wrap
	localparam int SUM_BW = `ACI_BW + 1;
	// largest output value, zero-extended to the sum width
	localparam logic signed [SUM_BW-1:0] O_MAX = {{(SUM_BW-`O_BW){1'b0}}, {`O_BW{1'b1}}};

	// ======================================================================
	// bias, relu, clip
	// ======================================================================

	logic signed [SUM_BW-1:0] biased;
	stage2_cnn_pkg::ofmap_t clipped;
	stage2_cnn_pkg::ofmap_t r_ot_fmap;
	logic r_valid;

	always_comb begin
		// both operands sign-extended
		biased = $signed(i_ch_acc) + $signed(i_bias);
		if (biased < 0) begin
			// relu
			clipped = '0;
		end else if (biased > O_MAX) begin
			// saturate at all ones
			clipped = '1;
		end else begin
			clipped = biased[`O_BW-1:0];
		end
	end

	// output pixel holds between strobes
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			r_ot_fmap <= '0;
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_in_valid;
			if (i_in_valid) begin
				r_ot_fmap <= clipped;
			end
		end
	end

	assign o_ot_valid = r_valid;
	assign o_ot_fmap = r_ot_fmap;

endmodule

// ==== stage2_cnn_core.sv ====
`timescale 1ns/1ps
`include "stage2_cnn_params.svh"

module stage2_cnn_core (
	input  logic clk,
	input  logic reset_n,
	// one strobe per output pixel, no back-pressure
	input  logic i_in_valid,
	// element c*25 + y*5 + x
	input  stage2_cnn_pkg::fmap_t [`CI*`KX*`KY-1:0] i_in_fmap,
	// same layout as the fmap window
	input  stage2_cnn_pkg::weight_t [`CI*`KX*`KY-1:0] i_cnn_weight,
	input  stage2_cnn_pkg::bias_t i_bias,
	// 5 cycles after i_in_valid
	output logic o_ot_valid,
	output stage2_cnn_pkg::ofmap_t o_ot_fmap
);

	// taps per channel window
	localparam int KK = `KX * `KY;

	// ======================================================================
	// per-channel kernels, 3-cycle latency
	// ======================================================================

	logic [`CI-1:0] kernel_valid;
	stage2_cnn_pkg::acc_kernel_t [`CI-1:0] kernel_acc;

	for (genvar c = 0; c < `CI; c++) begin : gen_kernel
		// channel c takes its own 25-element slice
		stage2_cnn_kernel u_kernel (
			.clk             (clk),
			.reset_n         (reset_n),
			.i_in_valid      (i_in_valid),
			.i_in_fmap       (i_in_fmap[c*KK +: KK]),
			.i_cnn_weight    (i_cnn_weight[c*KK +: KK]),
			.o_ot_valid      (kernel_valid[c]),
			.o_ot_kernel_acc (kernel_acc[c])
		);
	end

	// ======================================================================
	// channel sum, 1 cycle
	// ======================================================================

	logic ch_valid;
	stage2_cnn_pkg::acc_ch_t ch_acc;

	// all kernels in lockstep, kernel 0 stands for the rest
	stage2_channel_acc u_channel_acc (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_in_valid   (kernel_valid[0]),
		.i_kernel_acc (kernel_acc),
		.o_ot_valid   (ch_valid),
		.o_ot_ch_acc  (ch_acc)
	);

	// ======================================================================
	// bias, relu and clip, 1 cycle
	// ======================================================================

	stage2_bias_relu u_bias_relu (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_in_valid (ch_valid),
		.i_ch_acc   (ch_acc),
		.i_bias     (i_bias),
		.o_ot_valid (o_ot_valid),
		.o_ot_fmap  (o_ot_fmap)
	);

endmodule

// ==== stage2_cnn_core_assertions.sv ====
`timescale 1ns/1ps

module stage2_cnn_core_assertions (
	input logic clk,
	input logic reset_n,
	input logic i_in_valid,
	input logic o_ot_valid,
	input stage2_cnn_pkg::ofmap_t o_ot_fmap
);

	// ======================================================================
	// valid timing
	// ======================================================================

	// every strobe comes out 5 cycles later
	a_latency: assert property (@(posedge clk) disable iff (!reset_n)
		i_in_valid |-> ##5 o_ot_valid)
		else $error("o_ot_valid not high 5 cycles after i_in_valid");

	// and no pulse without a strobe 5 cycles earlier
	a_no_spurious: assert property (@(posedge clk) disable iff (!reset_n)
		o_ot_valid |-> $past(i_in_valid, 5))
		else $error("o_ot_valid high without a matching i_in_valid");

	// quiet while in reset
	a_reset_quiet: assert property (@(posedge clk)
		!reset_n |-> !o_ot_valid)
		else $error("o_ot_valid high during reset");

	// ======================================================================
	// output data
	// ======================================================================

	// result register only loads on a valid pulse
	a_hold: assert property (@(posedge clk) disable iff (!reset_n)
		!o_ot_valid |-> $stable(o_ot_fmap))
		else $error("o_ot_fmap changed while o_ot_valid low");

	a_known: assert property (@(posedge clk) disable iff (!reset_n)
		o_ot_valid |-> !$isunknown(o_ot_fmap))
		else $error("o_ot_fmap unknown on a valid pulse");

endmodule

bind stage2_cnn_core stage2_cnn_core_assertions u_assertions (
	.clk        (clk),
	.reset_n    (reset_n),
	.i_in_valid (i_in_valid),
	.o_ot_valid (o_ot_valid),
	.o_ot_fmap  (o_ot_fmap)
);

// ==== stage2_cnn_core_tb.sv ====
`timescale 1ns/1ps
`include "stage2_cnn_params.svh"

module stage2_cnn_core_tb;

	localparam int NROWS = 24;
	localparam int RESET_CYCLES = 8;
	// about 10 cycles per row, plus reset, plus drain slack
	localparam int WATCHDOG_CYCLES = NROWS * 10 + RESET_CYCLES + 50;
	localparam logic [31:0] SEED_INIT = 32'he5c02476;
	localparam int KK = `KX * `KY;
	localparam int TAPS = `CI * KK;
	// strobe to output valid, counted in testbench cycles
	localparam int LATENCY = 5;

	// stimulus modes
	localparam int MODE_ZERO = 0;
	localparam int MODE_ONES = 1;
	localparam int MODE_RSMALL = 2;
	localparam int MODE_RFULL = 3;
	localparam int MODE_EXTREME = 4;

	localparam int FMAP_MAX = (1 << (`IBW - 1)) - 1;
	localparam int FMAP_MIN = -(1 << (`IBW - 1));
	localparam int W_MAX = (1 << (`W_BW - 1)) - 1;
	localparam int W_MIN = -(1 << (`W_BW - 1));
	localparam longint O_MAX = (longint'(1) << `O_BW) - 1;

	logic clk;
	logic reset_n;
	logic in_valid;
	stage2_cnn_pkg::fmap_t [TAPS-1:0] in_fmap;
	stage2_cnn_pkg::weight_t [TAPS-1:0] in_weight;
	stage2_cnn_pkg::bias_t bias;
	logic ot_valid;
	stage2_cnn_pkg::ofmap_t ot_fmap;

	// stimulus table, one entry per pixel
	int row_mode [NROWS];
	int row_bias [NROWS];
	bit row_gap [NROWS];
	int row_pick [NROWS];

	// current window, element c*25 + y*5 + x
	int win_fmap [TAPS];
	int win_weight [TAPS];

	// expected results and the cycle each is due
	logic [`O_BW-1:0] exp_q [$];
	longint due_q [$];

	longint cycle_cnt;
	stage2_cnn_pkg::ofmap_t last_out;
	stage2_cnn_pkg::ofmap_t exp_fmap;
	longint exp_cycle;
	int n_checked;
	int cur_bias;
	integer seed;

	stage2_cnn_core DUT (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_in_valid   (in_valid),
		.i_in_fmap    (in_fmap),
		.i_cnn_weight (in_weight),
		.i_bias       (bias),
		.o_ot_valid   (ot_valid),
		.o_ot_fmap    (ot_fmap)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ======================================================================
	// helpers
	// ======================================================================

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic set_row(input int r, input int mode, input int b, input bit gap,
			input int pick);
		row_mode[r] = mode;
		row_bias[r] = b;
		row_gap[r] = gap;
		row_pick[r] = pick;
	endtask

	// builds the next window in win_fmap / win_weight
	task automatic fill_window(input int mode, input int pick);
		for (int k = 0; k < TAPS; k++) begin
			case (mode)
				MODE_ZERO: begin
					win_fmap[k] = 0;
					win_weight[k] = 0;
				end
				MODE_ONES: begin
					win_fmap[k] = 1;
					win_weight[k] = (pick == 1) ? -1 : 1;
				end
				MODE_RSMALL: begin
					win_fmap[k] = $random(seed) % 8;
					win_weight[k] = $random(seed) % 4;
				end
				MODE_RFULL: begin
					// low bits of a random word, sign-extended
					win_fmap[k] = int'(stage2_cnn_pkg::fmap_t'($random(seed)));
					win_weight[k] = int'(stage2_cnn_pkg::weight_t'($random(seed)));
				end
				default: begin
					case (pick)
						0: begin
							win_fmap[k] = FMAP_MAX;
							win_weight[k] = W_MAX;
						end
						1: begin
							// most-negative fmap, one negative and one positive tap
							win_fmap[k] = FMAP_MIN;
							if (k % KK == 0)
								win_weight[k] = W_MIN;
							else if (k % KK == KK - 1)
								win_weight[k] = W_MAX;
							else
								win_weight[k] = 0;
						end
						default: begin
							win_fmap[k] = FMAP_MIN;
							win_weight[k] = W_MIN;
						end
					endcase
				end
			endcase
		end
	endtask

	// sum of all channel products, then bias, relu and clip
	function automatic logic [`O_BW-1:0] ref_pixel(input int b);
		longint acc;
		int idx;
		acc = 0;
		for (int c = 0; c < `CI; c++) begin
			for (int y = 0; y < `KY; y++) begin
				for (int x = 0; x < `KX; x++) begin
					idx = c * KK + y * `KX + x;
					acc = acc + longint'(win_fmap[idx]) * longint'(win_weight[idx]);
				end
			end
		end
		acc = acc + b;
		if (acc < 0)
			return '0;
		else if (acc > O_MAX)
			return '1;
		return acc[`O_BW-1:0];
	endfunction

	// one strobe with the current window
	task automatic apply_pixel(input int b);
		in_valid = 1'b1;
		bias = stage2_cnn_pkg::bias_t'(b);
		for (int k = 0; k < TAPS; k++) begin
			in_fmap[k] = stage2_cnn_pkg::fmap_t'(win_fmap[k]);
			in_weight[k] = stage2_cnn_pkg::weight_t'(win_weight[k]);
		end
		exp_q.push_back(ref_pixel(b));
		due_q.push_back(cycle_cnt + LATENCY);
	endtask

	// idle until every pixel in flight has come out
	task automatic drain_pipeline();
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// ======================================================================
	// output monitor, sampled on the falling edge
	// ======================================================================

	always @(negedge clk) begin
		if (reset_n) begin
			if (ot_valid) begin
				if (exp_q.size() == 0) begin
					$display("Error at %0t: output valid with no pixel in flight", $time);
					$display("Something failed");
					$fatal(1, "unexpected output");
				end else begin
					exp_fmap = exp_q.pop_front();
					exp_cycle = due_q.pop_front();
					check_value("o_ot_fmap", ot_fmap, exp_fmap);
					check_value("o_ot_valid cycle", cycle_cnt, exp_cycle);
					last_out = ot_fmap;
					n_checked++;
				end
			end else begin
				// output holds between pulses
				check_value("o_ot_fmap (idle)", ot_fmap, last_out);
			end
		end
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Error: run timed out after %0d cycles with %0d results outstanding",
			WATCHDOG_CYCLES, exp_q.size());
		$display("Something failed");
		$fatal(1, "timeout");
	end

	// ======================================================================
	// main sequence
	// ======================================================================

	initial begin
		seed = SEED_INIT;
		clk = 1'b0;
		reset_n = 1'b0;
		in_valid = 1'b0;
		in_fmap = '0;
		in_weight = '0;
		bias = '0;
		cycle_cnt = 0;
		last_out = '0;
		n_checked = 0;
		cur_bias = 0;

		// row, mode, bias, gap, pick
		set_row(0, MODE_ZERO, 0, 1, 0);
		set_row(1, MODE_ONES, 100, 1, 0);
		set_row(2, MODE_ONES, -200, 1, 0);
		set_row(3, MODE_ONES, -200, 1, 1);
		set_row(4, MODE_ONES, 1000, 1, 0);
		set_row(5, MODE_ONES, 32767, 1, 0);
		set_row(6, MODE_ONES, -32768, 1, 1);
		// six back-to-back strobes
		set_row(7, MODE_RSMALL, 5, 0, 0);
		set_row(8, MODE_RSMALL, 5, 0, 0);
		set_row(9, MODE_RSMALL, 5, 0, 0);
		set_row(10, MODE_RSMALL, 5, 0, 0);
		set_row(11, MODE_RSMALL, 5, 0, 0);
		set_row(12, MODE_RSMALL, 5, 1, 0);
		set_row(13, MODE_EXTREME, 0, 1, 0);
		set_row(14, MODE_EXTREME, 0, 1, 1);
		set_row(15, MODE_EXTREME, -32768, 1, 2);
		set_row(16, MODE_RFULL, 0, 0, 0);
		set_row(17, MODE_RFULL, 0, 0, 0);
		set_row(18, MODE_RFULL, 0, 0, 0);
		set_row(19, MODE_RFULL, 0, 1, 0);
		set_row(20, MODE_RSMALL, -50, 0, 0);
		set_row(21, MODE_RSMALL, -50, 0, 0);
		set_row(22, MODE_RSMALL, -50, 0, 0);
		set_row(23, MODE_RSMALL, -50, 1, 0);

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		// nothing in flight straight after reset
		@(negedge clk);
		check_value("o_ot_valid", ot_valid, 0);
		check_value("DUT.kernel_valid", DUT.kernel_valid, 0);
		check_value("DUT.ch_valid", DUT.ch_valid, 0);
		check_value("o_ot_fmap", ot_fmap, 0);

		for (int r = 0; r < NROWS; r++) begin
			// bias may only move with the pipeline empty
			if (row_bias[r] != cur_bias) begin
				drain_pipeline();
			end
			fill_window(row_mode[r], row_pick[r]);
			@(negedge clk);
			apply_pixel(row_bias[r]);
			cur_bias = row_bias[r];
			if (row_gap[r]) begin
				drain_pipeline();
			end
		end

		drain_pipeline();
		// a few idle cycles for the hold check
		repeat (4) @(negedge clk);

		if (exp_q.size() == 0 && n_checked == NROWS) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Error: %0d of %0d results seen, %0d still expected",
				n_checked, NROWS, exp_q.size());
			$display("Something failed");
			$fatal(1, "result count mismatch");
		end
	end

endmodule

// ==== build.f ====
+incdir+.
stage2_cnn_pkg.sv
stage2_cnn_kernel.sv
stage2_channel_acc.sv
stage2_bias_relu.sv
stage2_cnn_core.sv
stage2_cnn_core_assertions.sv
stage2_cnn_core_tb.sv

// ==== Bender.yml ====
package:
  name: stage2_cnn_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - stage2_cnn_pkg.sv
      - stage2_cnn_kernel.sv
      - stage2_channel_acc.sv
      - stage2_bias_relu.sv
      - stage2_cnn_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - stage2_cnn_core_assertions.sv
      - stage2_cnn_core_tb.sv
